/* sched_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, dispatch kind codes and the
// instruction word views for the issue scheduler.
// Referenced by scoped name from every module.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package sched_pkg;

  localparam int XLEN           = 64;
  localparam int VADDR_W        = 39;
  localparam int INSTR_W        = 32;
  localparam int REG_ADDR_W     = 5;
  localparam int QUEUE_DEPTH    = 4;
  localparam int QUEUE_PTR_W    = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CNT_W    = $clog2(QUEUE_DEPTH + 1);
  localparam int PREFETCH_COUNT = 4;
  localparam int PREF_CNT_W     = $clog2(PREFETCH_COUNT + 1);
  localparam int STRIDE_W       = 8;
  localparam int KIND_W         = 3;

  // dispatch kinds, listed in grant priority order
  localparam logic [KIND_W-1:0] KIND_LATE_WB   = KIND_W'(0);
  localparam logic [KIND_W-1:0] KIND_RESUME    = KIND_W'(1);
  localparam logic [KIND_W-1:0] KIND_INTERRUPT = KIND_W'(2);
  localparam logic [KIND_W-1:0] KIND_INSTR     = KIND_W'(3);
  localparam logic [KIND_W-1:0] KIND_FETCH_EXC = KIND_W'(4);
  localparam logic [KIND_W-1:0] KIND_PREFETCH  = KIND_W'(5);

  localparam logic [6:0] OPCODE_LOAD = 7'b0000011;

  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } rtype;
    struct packed {
      logic [11:0]           imm12;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } itype;
  } rv_instr_u;

endpackage

`default_nettype wire

/* issue_queue.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-entry circular queue of fetch entries.
// The oldest entry is shown combinationally and
// leaves on deq_i; clr_i flushes everything.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module issue_queue
  (input  wire                               clk_i,
   input  wire                               rst_i,
   input  wire                               clr_i,
   input  wire                               fe_queue_v_i,
   input  wire [sched_pkg::VADDR_W-1:0]      fe_pc_i,
   input  sched_pkg::rv_instr_u              fe_instr_i,
   input  wire                               fe_exc_i,
   input  wire                               deq_i,
   output logic                              fe_queue_ready_and_o,
   output logic                              head_v_o,
   output logic [sched_pkg::VADDR_W-1:0]     head_pc_o,
   output sched_pkg::rv_instr_u              head_instr_o,
   output logic                              head_exc_o);

  logic [sched_pkg::VADDR_W-1:0]     pc_mem    [sched_pkg::QUEUE_DEPTH];
  sched_pkg::rv_instr_u              instr_mem [sched_pkg::QUEUE_DEPTH];
  logic                              exc_mem   [sched_pkg::QUEUE_DEPTH];
  logic [sched_pkg::QUEUE_PTR_W-1:0] rd_ptr;
  logic [sched_pkg::QUEUE_PTR_W-1:0] wr_ptr;
  logic [sched_pkg::QUEUE_CNT_W-1:0] count;
  logic                              enq;
  logic                              deq;

  assign fe_queue_ready_and_o =
    (count != sched_pkg::QUEUE_CNT_W'(sched_pkg::QUEUE_DEPTH));
  assign head_v_o = (count != '0);
  assign enq = fe_queue_v_i & fe_queue_ready_and_o;
  assign deq = deq_i & head_v_o;

  assign head_pc_o    = pc_mem[rd_ptr];
  assign head_instr_o = instr_mem[rd_ptr];
  assign head_exc_o   = exc_mem[rd_ptr];

  always_ff @(posedge clk_i)
  begin
    if (enq)
    begin
      pc_mem[wr_ptr]    <= fe_pc_i;
      instr_mem[wr_ptr] <= fe_instr_i;
      exc_mem[wr_ptr]   <= fe_exc_i;
    end
  end

  // clear wins over enqueue and dequeue
  always_ff @(posedge clk_i)
  begin
    if (rst_i || clr_i)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (enq)
        wr_ptr <= wr_ptr + sched_pkg::QUEUE_PTR_W'(1);
      if (deq)
        rd_ptr <= rd_ptr + sched_pkg::QUEUE_PTR_W'(1);
      if (enq && !deq)
        count <= count + sched_pkg::QUEUE_CNT_W'(1);
      else if (deq && !enq)
        count <= count - sched_pkg::QUEUE_CNT_W'(1);
    end
  end

endmodule

`default_nettype wire

/* int_regfile.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 x 64 integer register file, one write port
// and two asynchronous reads. x0 always reads 0.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module int_regfile
  (input  wire                                clk_i,
   input  wire                                rst_i,
   input  wire                                w_v_i,
   input  wire  [sched_pkg::REG_ADDR_W-1:0]   w_addr_i,
   input  wire  [sched_pkg::XLEN-1:0]         w_data_i,
   input  wire  [sched_pkg::REG_ADDR_W-1:0]   rs1_addr_i,
   input  wire  [sched_pkg::REG_ADDR_W-1:0]   rs2_addr_i,
   output logic [sched_pkg::XLEN-1:0]         rs1_data_o,
   output logic [sched_pkg::XLEN-1:0]         rs2_data_o);

  logic [sched_pkg::XLEN-1:0] regs [2**sched_pkg::REG_ADDR_W];

  // x0 stays at its reset value of zero
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      regs <= '{default: '0};
    else if (w_v_i && (w_addr_i != '0))
      regs[w_addr_i] <= w_data_i;
  end

  // no bypass so a write shows up next cycle
  assign rs1_data_o = regs[rs1_addr_i];
  assign rs2_data_o = regs[rs2_addr_i];

endmodule

`default_nettype wire

/* dispatch_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Grants the single dispatch port each cycle and
// muxes the winner onto the dispatch outputs.
// Purely combinational; returns yumi or dequeue.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module dispatch_arbiter
  (input  wire                                hazard_v_i,
   input  wire                                late_wb_v_i,
   input  wire                                late_wb_force_i,
   input  wire  [sched_pkg::REG_ADDR_W-1:0]   late_wb_rd_i,
   input  wire  [sched_pkg::XLEN-1:0]         late_wb_data_i,
   input  wire                                resume_i,
   input  wire                                irq_pending_i,
   input  wire                                head_v_i,
   input  wire  [sched_pkg::VADDR_W-1:0]      head_pc_i,
   input  sched_pkg::rv_instr_u               head_instr_i,
   input  wire                                head_exc_i,
   input  wire  [sched_pkg::XLEN-1:0]         rs1_data_i,
   input  wire  [sched_pkg::XLEN-1:0]         rs2_data_i,
   input  wire                                pref_v_i,
   input  wire  [sched_pkg::VADDR_W-1:0]      pref_addr_i,
   output logic                               late_wb_yumi_o,
   output logic                               deq_o,
   output logic                               pref_yumi_o,
   output logic                               dispatch_v_o,
   output logic [sched_pkg::KIND_W-1:0]       dispatch_kind_o,
   output logic [sched_pkg::VADDR_W-1:0]      dispatch_pc_o,
   output sched_pkg::rv_instr_u               dispatch_instr_o,
   output logic [sched_pkg::XLEN-1:0]         dispatch_rs1_o,
   output logic [sched_pkg::XLEN-1:0]         dispatch_rs2_o);

  logic queued;
  logic wb_g;
  logic resume_g;
  logic irq_g;

  assign queued   = head_v_i & ~hazard_v_i;
  // unforced writebacks slip in only when the queue is idle
  assign wb_g     = late_wb_v_i & (late_wb_force_i | ~queued);
  assign resume_g = ~late_wb_v_i & ~hazard_v_i & resume_i;
  assign irq_g    = ~late_wb_v_i & ~hazard_v_i & ~resume_i & irq_pending_i;

  assign late_wb_yumi_o = wb_g;
  assign deq_o          = queued & ~wb_g & ~resume_g & ~irq_g;
  assign pref_yumi_o    = pref_v_i & ~queued & ~wb_g & ~resume_g & ~irq_g;
  assign dispatch_v_o   = wb_g | resume_g | irq_g | deq_o | pref_yumi_o;

  always_comb
  begin
    dispatch_kind_o  = sched_pkg::KIND_LATE_WB;
    dispatch_pc_o    = '0;
    dispatch_instr_o = '0;
    dispatch_rs1_o   = '0;
    dispatch_rs2_o   = '0;
    if (wb_g)
    begin
      dispatch_instr_o.rtype.rd = late_wb_rd_i;
      dispatch_rs2_o            = late_wb_data_i;
    end
    else if (resume_g)
      dispatch_kind_o = sched_pkg::KIND_RESUME;
    else if (irq_g)
      dispatch_kind_o = sched_pkg::KIND_INTERRUPT;
    else if (deq_o && head_exc_i)
    begin
      dispatch_kind_o  = sched_pkg::KIND_FETCH_EXC;
      dispatch_pc_o    = head_pc_i;
      dispatch_instr_o = head_instr_i;
      dispatch_rs1_o   = sched_pkg::XLEN'(head_pc_i);
    end
    else if (deq_o)
    begin
      dispatch_kind_o  = sched_pkg::KIND_INSTR;
      dispatch_pc_o    = head_pc_i;
      dispatch_instr_o = head_instr_i;
      dispatch_rs1_o   = rs1_data_i;
      dispatch_rs2_o   = rs2_data_i;
    end
    else if (pref_yumi_o)
    begin
      dispatch_kind_o = sched_pkg::KIND_PREFETCH;
      dispatch_rs1_o  = sched_pkg::XLEN'(pref_addr_i);
    end
  end

endmodule

`default_nettype wire

/* stride_detector.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Watches dispatched loads. Pulses confirm_o when
// one load pc repeats with the same small stride,
// giving the latest address and that stride.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module stride_detector
  (input  wire                               clk_i,
   input  wire                               rst_i,
   input  wire                               load_v_i,
   input  wire  [sched_pkg::VADDR_W-1:0]     pc_i,
   input  sched_pkg::rv_instr_u              instr_i,
   input  wire  [sched_pkg::XLEN-1:0]        rs1_data_i,
   output logic                              confirm_o,
   output logic [sched_pkg::VADDR_W-1:0]     base_o,
   output logic [sched_pkg::STRIDE_W-1:0]    stride_o);

  logic                              tracked_v;
  logic [sched_pkg::VADDR_W-1:0]     last_pc;
  logic [sched_pkg::VADDR_W-1:0]     last_addr;
  logic [sched_pkg::STRIDE_W-1:0]    last_delta;
  logic [sched_pkg::VADDR_W-1:0]     eff_addr;
  logic [sched_pkg::VADDR_W-1:0]     delta;
  logic                              fits;
  logic                              same_pc;

  assign eff_addr = rs1_data_i[sched_pkg::VADDR_W-1:0]
                  + sched_pkg::VADDR_W'($signed(instr_i.itype.imm12));
  assign delta    = eff_addr - last_addr;
  // upper bits all copies of the stride sign bit
  assign fits     = (&delta[sched_pkg::VADDR_W-1:sched_pkg::STRIDE_W-1])
                  | ~(|delta[sched_pkg::VADDR_W-1:sched_pkg::STRIDE_W-1]);
  assign same_pc  = tracked_v && (pc_i == last_pc);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      tracked_v  <= 1'b0;
      last_delta <= '0;
      confirm_o  <= 1'b0;
    end
    else
    begin
      confirm_o <= load_v_i && same_pc && fits && (last_delta != '0)
                && (delta[sched_pkg::STRIDE_W-1:0] == last_delta);
      if (load_v_i)
      begin
        tracked_v  <= 1'b1;
        // zero delta marks no usable stride yet
        last_delta <= (same_pc && fits) ? delta[sched_pkg::STRIDE_W-1:0] : '0;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (load_v_i)
    begin
      last_pc   <= pc_i;
      last_addr <= eff_addr;
      base_o    <= eff_addr;
      stride_o  <= delta[sched_pkg::STRIDE_W-1:0];
    end
  end

endmodule

`default_nettype wire

/* prefetch_generator.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Offers PREFETCH_COUNT strided addresses after a
// confirm, one per granted cycle. Holds an offer
// until yumi_i; confirms while busy are dropped.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module prefetch_generator
  (input  wire                               clk_i,
   input  wire                               rst_i,
   input  wire                               confirm_i,
   input  wire  [sched_pkg::VADDR_W-1:0]     base_i,
   input  wire  [sched_pkg::STRIDE_W-1:0]    stride_i,
   input  wire                               yumi_i,
   output logic                              v_o,
   output logic [sched_pkg::VADDR_W-1:0]     addr_o);

  logic [sched_pkg::PREF_CNT_W-1:0] remaining;
  logic [sched_pkg::STRIDE_W-1:0]   stride_q;

  assign v_o = (remaining != '0);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      remaining <= '0;
    else if (!v_o && confirm_i)
      remaining <= sched_pkg::PREF_CNT_W'(sched_pkg::PREFETCH_COUNT);
    else if (v_o && yumi_i)
      remaining <= remaining - sched_pkg::PREF_CNT_W'(1);
  end

  // first offer is already one stride past the base
  always_ff @(posedge clk_i)
  begin
    if (!v_o && confirm_i)
    begin
      stride_q <= stride_i;
      addr_o   <= base_i + sched_pkg::VADDR_W'($signed(stride_i));
    end
    else if (v_o && yumi_i)
      addr_o <= addr_o + sched_pkg::VADDR_W'($signed(stride_q));
  end

endmodule

`default_nettype wire

/* scheduler.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue scheduler top. Joins the fetch queue,
// integer register file, dispatch arbiter and the
// stride prefetch path onto one dispatch port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module scheduler
  (input  wire                                clk_i,
   input  wire                                rst_i,
   input  wire                                fe_queue_v_i,
   input  wire  [sched_pkg::VADDR_W-1:0]      fe_pc_i,
   input  sched_pkg::rv_instr_u               fe_instr_i,
   input  wire                                fe_exc_i,
   output logic                               fe_queue_ready_and_o,
   input  wire                                iwb_v_i,
   input  wire  [sched_pkg::REG_ADDR_W-1:0]   iwb_rd_i,
   input  wire  [sched_pkg::XLEN-1:0]         iwb_data_i,
   input  wire                                late_wb_v_i,
   input  wire                                late_wb_force_i,
   input  wire  [sched_pkg::REG_ADDR_W-1:0]   late_wb_rd_i,
   input  wire  [sched_pkg::XLEN-1:0]         late_wb_data_i,
   output logic                               late_wb_yumi_o,
   input  wire                                hazard_v_i,
   input  wire                                resume_i,
   input  wire                                irq_pending_i,
   input  wire                                clear_iss_i,
   output logic                               dispatch_v_o,
   output logic [sched_pkg::KIND_W-1:0]       dispatch_kind_o,
   output logic [sched_pkg::VADDR_W-1:0]      dispatch_pc_o,
   output sched_pkg::rv_instr_u               dispatch_instr_o,
   output logic [sched_pkg::XLEN-1:0]         dispatch_rs1_o,
   output logic [sched_pkg::XLEN-1:0]         dispatch_rs2_o);

  logic                              head_v;
  logic [sched_pkg::VADDR_W-1:0]     head_pc;
  sched_pkg::rv_instr_u              head_instr;
  logic                              head_exc;
  logic                              deq;
  logic [sched_pkg::XLEN-1:0]        irf_rs1;
  logic [sched_pkg::XLEN-1:0]        irf_rs2;
  logic                              load_v;
  logic                              confirm;
  logic [sched_pkg::VADDR_W-1:0]     pref_base;
  logic [sched_pkg::STRIDE_W-1:0]    pref_stride;
  logic                              pref_v;
  logic [sched_pkg::VADDR_W-1:0]     pref_addr;
  logic                              pref_yumi;

  issue_queue i_issue_queue
    (.clk_i                (clk_i),
     .rst_i                (rst_i),
     .clr_i                (clear_iss_i),
     .fe_queue_v_i         (fe_queue_v_i),
     .fe_pc_i              (fe_pc_i),
     .fe_instr_i           (fe_instr_i),
     .fe_exc_i             (fe_exc_i),
     .deq_i                (deq),
     .fe_queue_ready_and_o (fe_queue_ready_and_o),
     .head_v_o             (head_v),
     .head_pc_o            (head_pc),
     .head_instr_o         (head_instr),
     .head_exc_o           (head_exc));

  int_regfile i_int_regfile
    (.clk_i      (clk_i),
     .rst_i      (rst_i),
     .w_v_i      (iwb_v_i),
     .w_addr_i   (iwb_rd_i),
     .w_data_i   (iwb_data_i),
     .rs1_addr_i (head_instr.rtype.rs1),
     .rs2_addr_i (head_instr.rtype.rs2),
     .rs1_data_o (irf_rs1),
     .rs2_data_o (irf_rs2));

  dispatch_arbiter i_dispatch_arbiter
    (.hazard_v_i       (hazard_v_i),
     .late_wb_v_i      (late_wb_v_i),
     .late_wb_force_i  (late_wb_force_i),
     .late_wb_rd_i     (late_wb_rd_i),
     .late_wb_data_i   (late_wb_data_i),
     .resume_i         (resume_i),
     .irq_pending_i    (irq_pending_i),
     .head_v_i         (head_v),
     .head_pc_i        (head_pc),
     .head_instr_i     (head_instr),
     .head_exc_i       (head_exc),
     .rs1_data_i       (irf_rs1),
     .rs2_data_i       (irf_rs2),
     .pref_v_i         (pref_v),
     .pref_addr_i      (pref_addr),
     .late_wb_yumi_o   (late_wb_yumi_o),
     .deq_o            (deq),
     .pref_yumi_o      (pref_yumi),
     .dispatch_v_o     (dispatch_v_o),
     .dispatch_kind_o  (dispatch_kind_o),
     .dispatch_pc_o    (dispatch_pc_o),
     .dispatch_instr_o (dispatch_instr_o),
     .dispatch_rs1_o   (dispatch_rs1_o),
     .dispatch_rs2_o   (dispatch_rs2_o));

  // only real loads leaving the queue feed the detector
  assign load_v = dispatch_v_o
               && (dispatch_kind_o == sched_pkg::KIND_INSTR)
               && (dispatch_instr_o.itype.opcode == sched_pkg::OPCODE_LOAD);

  stride_detector i_stride_detector
    (.clk_i      (clk_i),
     .rst_i      (rst_i),
     .load_v_i   (load_v),
     .pc_i       (head_pc),
     .instr_i    (head_instr),
     .rs1_data_i (irf_rs1),
     .confirm_o  (confirm),
     .base_o     (pref_base),
     .stride_o   (pref_stride));

  prefetch_generator i_prefetch_generator
    (.clk_i     (clk_i),
     .rst_i     (rst_i),
     .confirm_i (confirm),
     .base_i    (pref_base),
     .stride_i  (pref_stride),
     .yumi_i    (pref_yumi),
     .v_o       (pref_v),
     .addr_o    (pref_addr));

endmodule

`default_nettype wire

/* tb_scheduler.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Table-driven testbench for the issue scheduler.
// Rows come from a small register and stride model
// at start-up and are applied one per clock cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module tb_scheduler;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int MARGIN       = 20;
  localparam int STRIDE       = 8;
  localparam logic [sched_pkg::VADDR_W-1:0] PC_A = 39'h00_0000_1000;
  localparam logic [sched_pkg::VADDR_W-1:0] PC_B = 39'h00_0000_1004;
  localparam logic [sched_pkg::VADDR_W-1:0] PC_C = 39'h00_0000_2000;
  localparam logic [sched_pkg::VADDR_W-1:0] PC_D = 39'h00_0000_2040;
  localparam logic [sched_pkg::VADDR_W-1:0] PC_E = 39'h40_0000_0ffc;
  localparam logic [sched_pkg::VADDR_W-1:0] PC_L = 39'h00_0000_3000;
  localparam logic [sched_pkg::VADDR_W-1:0] PC_F = 39'h00_0000_3100;
  localparam logic [sched_pkg::VADDR_W-1:0] PC_G = 39'h00_0000_4000;
  localparam sched_pkg::rv_instr_u EXC_WORD = 32'hdead_beef;

  typedef struct packed {
    logic                             fe_v;
    logic [sched_pkg::VADDR_W-1:0]    fe_pc;
    sched_pkg::rv_instr_u             fe_instr;
    logic                             fe_exc;
    logic                             iwb_v;
    logic [sched_pkg::REG_ADDR_W-1:0] iwb_rd;
    logic [sched_pkg::XLEN-1:0]       iwb_data;
    logic                             lwb_v;
    logic                             lwb_force;
    logic [sched_pkg::REG_ADDR_W-1:0] lwb_rd;
    logic [sched_pkg::XLEN-1:0]       lwb_data;
    logic                             hazard;
    logic                             resume;
    logic                             irq;
    logic                             clear;
    logic                             exp_v;
    logic                             exp_yumi;
    logic                             exp_ready;
    logic [sched_pkg::KIND_W-1:0]     exp_kind;
    logic [sched_pkg::VADDR_W-1:0]    exp_pc;
    sched_pkg::rv_instr_u             exp_instr;
    logic [sched_pkg::XLEN-1:0]       exp_rs1;
    logic [sched_pkg::XLEN-1:0]       exp_rs2;
  } row_t;

  logic                             clk;
  logic                             rst;
  logic                             fe_v;
  logic [sched_pkg::VADDR_W-1:0]    fe_pc;
  sched_pkg::rv_instr_u             fe_instr;
  logic                             fe_exc;
  logic                             fe_ready;
  logic                             iwb_v;
  logic [sched_pkg::REG_ADDR_W-1:0] iwb_rd;
  logic [sched_pkg::XLEN-1:0]       iwb_data;
  logic                             lwb_v;
  logic                             lwb_force;
  logic [sched_pkg::REG_ADDR_W-1:0] lwb_rd;
  logic [sched_pkg::XLEN-1:0]       lwb_data;
  logic                             lwb_yumi;
  logic                             hazard;
  logic                             resume;
  logic                             irq;
  logic                             clear;
  logic                             dispatch_v;
  logic [sched_pkg::KIND_W-1:0]     dispatch_kind;
  logic [sched_pkg::VADDR_W-1:0]    dispatch_pc;
  sched_pkg::rv_instr_u             dispatch_instr;
  logic [sched_pkg::XLEN-1:0]       dispatch_rs1;
  logic [sched_pkg::XLEN-1:0]       dispatch_rs2;

  row_t                       rows[$];
  string                      row_names[$];
  logic [sched_pkg::XLEN-1:0] model_regs [32];
  logic                       table_ready;

  scheduler i_dut
    (.clk_i (clk), .rst_i (rst),
     .fe_queue_v_i (fe_v), .fe_pc_i (fe_pc), .fe_instr_i (fe_instr), .fe_exc_i (fe_exc),
     .fe_queue_ready_and_o (fe_ready),
     .iwb_v_i (iwb_v), .iwb_rd_i (iwb_rd), .iwb_data_i (iwb_data),
     .late_wb_v_i (lwb_v), .late_wb_force_i (lwb_force), .late_wb_rd_i (lwb_rd),
     .late_wb_data_i (lwb_data), .late_wb_yumi_o (lwb_yumi),
     .hazard_v_i (hazard), .resume_i (resume), .irq_pending_i (irq),
     .clear_iss_i (clear),
     .dispatch_v_o (dispatch_v), .dispatch_kind_o (dispatch_kind),
     .dispatch_pc_o (dispatch_pc), .dispatch_instr_o (dispatch_instr),
     .dispatch_rs1_o (dispatch_rs1), .dispatch_rs2_o (dispatch_rs2));

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic row_t blank_row();
    row_t r;
    r = '0;
    r.exp_ready = 1'b1;
    return r;
  endfunction

  function automatic sched_pkg::rv_instr_u rtype_word(input logic [4:0] rs1,
                                                      input logic [4:0] rs2);
    sched_pkg::rv_instr_u w;
    w = '0;
    w.rtype.opcode = 7'b0110011;
    w.rtype.rd     = 5'd1;
    w.rtype.rs1    = rs1;
    w.rtype.rs2    = rs2;
    return w;
  endfunction

  function automatic sched_pkg::rv_instr_u load_word(input logic [4:0] rs1,
                                                     input logic [11:0] imm);
    sched_pkg::rv_instr_u w;
    w = '0;
    w.itype.opcode = sched_pkg::OPCODE_LOAD;
    w.itype.funct3 = 3'b011;
    w.itype.rd     = 5'd10;
    w.itype.rs1    = rs1;
    w.itype.imm12  = imm;
    return w;
  endfunction

  function automatic row_t with_iwb(input row_t r, input logic [4:0] rd,
                                    input logic [sched_pkg::XLEN-1:0] data);
    r.iwb_v    = 1'b1;
    r.iwb_rd   = rd;
    r.iwb_data = data;
    return r;
  endfunction

  function automatic row_t with_fetch(input row_t r, input logic [sched_pkg::VADDR_W-1:0] pc,
                                      input sched_pkg::rv_instr_u instr, input logic exc);
    r.fe_v     = 1'b1;
    r.fe_pc    = pc;
    r.fe_instr = instr;
    r.fe_exc   = exc;
    return r;
  endfunction

  function automatic row_t with_lwb(input row_t r, input logic force_wb, input logic [4:0] rd,
                                    input logic [sched_pkg::XLEN-1:0] data);
    r.lwb_v     = 1'b1;
    r.lwb_force = force_wb;
    r.lwb_rd    = rd;
    r.lwb_data  = data;
    return r;
  endfunction

  // queue head dispatch with operands from the register model
  function automatic row_t expect_head(input row_t r, input logic [sched_pkg::VADDR_W-1:0] pc,
                                       input sched_pkg::rv_instr_u instr, input logic exc);
    r.exp_v     = 1'b1;
    r.exp_pc    = pc;
    r.exp_instr = instr;
    if (exc)
    begin
      r.exp_kind = sched_pkg::KIND_FETCH_EXC;
      r.exp_rs1  = sched_pkg::XLEN'(pc);
    end
    else
    begin
      r.exp_kind = sched_pkg::KIND_INSTR;
      r.exp_rs1  = model_regs[instr.rtype.rs1];
      r.exp_rs2  = model_regs[instr.rtype.rs2];
    end
    return r;
  endfunction

  function automatic row_t expect_wb(input row_t r);
    r.exp_v              = 1'b1;
    r.exp_yumi           = 1'b1;
    r.exp_kind           = sched_pkg::KIND_LATE_WB;
    r.exp_instr.rtype.rd = r.lwb_rd;
    r.exp_rs2            = r.lwb_data;
    return r;
  endfunction

  function automatic row_t expect_kind(input row_t r, input logic [sched_pkg::KIND_W-1:0] kind);
    r.exp_v    = 1'b1;
    r.exp_kind = kind;
    return r;
  endfunction

  function automatic logic [sched_pkg::VADDR_W-1:0] prefetch_addr(
    input logic [sched_pkg::VADDR_W-1:0] base, input int k);
    return base + sched_pkg::VADDR_W'(k * STRIDE);
  endfunction

  function automatic row_t expect_pref(input row_t r, input logic [sched_pkg::VADDR_W-1:0] a);
    r.exp_v    = 1'b1;
    r.exp_kind = sched_pkg::KIND_PREFETCH;
    r.exp_rs1  = sched_pkg::XLEN'(a);
    return r;
  endfunction

  task automatic push_row(input string name, input row_t r);
    rows.push_back(r);
    row_names.push_back(name);
    // write lands at the end of the row
    if (r.iwb_v && (r.iwb_rd != 5'd0))
      model_regs[r.iwb_rd] = r.iwb_data;
  endtask

  task automatic build_table();
    row_t                          r;
    logic [sched_pkg::XLEN-1:0]    val_c;
    logic [sched_pkg::XLEN-1:0]    base_reg;
    logic [sched_pkg::VADDR_W-1:0] pf_base;
    sched_pkg::rv_instr_u          ld;

    model_regs = '{default: '0};
    val_c      = {$urandom, $urandom};
    base_reg   = sched_pkg::XLEN'($urandom & 32'h00ff_fff0);
    ld         = load_word(5'd9, 12'd16);
    pf_base    = '0;
    push_row("reset idle", blank_row());
    push_row("write x5", with_iwb(blank_row(), 5'd5, {$urandom, $urandom}));
    push_row("write x6", with_iwb(blank_row(), 5'd6, {$urandom, $urandom}));
    r = with_iwb(blank_row(), 5'd0, {$urandom, $urandom});
    push_row("fetch rtype x0 write", with_fetch(r, PC_A, rtype_word(5'd5, 5'd6), 1'b0));
    r = with_fetch(blank_row(), PC_B, rtype_word(5'd0, 5'd5), 1'b0);
    push_row("regs to operands", expect_head(r, PC_A, rtype_word(5'd5, 5'd6), 1'b0));
    push_row("x0 source", expect_head(blank_row(), PC_B, rtype_word(5'd0, 5'd5), 1'b0));
    push_row("fetch for wb", with_fetch(blank_row(), PC_C, rtype_word(5'd5, 5'd6), 1'b0));
    push_row("forced wb", expect_wb(with_lwb(blank_row(), 1'b1, 5'd7, {$urandom, $urandom})));
    r = with_lwb(blank_row(), 1'b0, 5'd8, val_c);
    push_row("unforced wb waits", expect_head(r, PC_C, rtype_word(5'd5, 5'd6), 1'b0));
    push_row("unforced wb", expect_wb(with_lwb(blank_row(), 1'b0, 5'd8, val_c)));
    r = blank_row();
    r.resume = 1'b1;
    r.irq    = 1'b1;
    push_row("resume over irq", expect_kind(r, sched_pkg::KIND_RESUME));
    r = blank_row();
    r.irq = 1'b1;
    push_row("irq", expect_kind(r, sched_pkg::KIND_INTERRUPT));
    r = with_fetch(blank_row(), PC_D, rtype_word(5'd6, 5'd0), 1'b0);
    r.hazard = 1'b1;
    r.resume = 1'b1;
    push_row("hazard blocks resume", r);
    r = blank_row();
    r.hazard = 1'b1;
    r.irq    = 1'b1;
    push_row("hazard blocks head", r);
    push_row("hazard released", expect_head(blank_row(), PC_D, rtype_word(5'd6, 5'd0), 1'b0));
    push_row("fetch exc", with_fetch(blank_row(), PC_E, EXC_WORD, 1'b1));
    push_row("exc dispatch", expect_head(blank_row(), PC_E, EXC_WORD, 1'b1));
    push_row("load setup", with_fetch(with_iwb(blank_row(), 5'd9, base_reg), PC_L, ld, 1'b0));
    for (int k = 1; k <= 3; k++)
    begin
      r = blank_row();
      if (k < 3)
        r = with_fetch(with_iwb(r, 5'd9, base_reg + sched_pkg::XLEN'(STRIDE * k)), PC_L, ld, 1'b0);
      // address of the latest load becomes the prefetch base
      pf_base = sched_pkg::VADDR_W'(model_regs[9])
              + sched_pkg::VADDR_W'($signed(ld.itype.imm12));
      push_row("stride load", expect_head(r, PC_L, ld, 1'b0));
    end
    push_row("confirm cycle", blank_row());
    r = blank_row();
    r.irq = 1'b1;
    push_row("irq over prefetch", expect_kind(r, sched_pkg::KIND_INTERRUPT));
    push_row("prefetch 1", expect_pref(blank_row(), prefetch_addr(pf_base, 1)));
    r = with_fetch(blank_row(), PC_F, rtype_word(5'd5, 5'd6), 1'b0);
    push_row("prefetch 2", expect_pref(r, prefetch_addr(pf_base, 2)));
    push_row("head over prefetch", expect_head(blank_row(), PC_F, rtype_word(5'd5, 5'd6), 1'b0));
    push_row("prefetch 3", expect_pref(blank_row(), prefetch_addr(pf_base, 3)));
    push_row("prefetch 4", expect_pref(blank_row(), prefetch_addr(pf_base, 4)));
    push_row("prefetch done", blank_row());
    for (int k = 0; k < sched_pkg::QUEUE_DEPTH; k++)
    begin
      r = with_fetch(blank_row(), PC_G + sched_pkg::VADDR_W'(4 * k), rtype_word(5'd5, 5'd6), 1'b0);
      r.hazard = 1'b1;
      push_row("fill queue", r);
    end
    r = with_fetch(blank_row(), PC_G, rtype_word(5'd5, 5'd6), 1'b0);
    r.hazard    = 1'b1;
    r.clear     = 1'b1;
    r.exp_ready = 1'b0;
    push_row("full then clear", r);
    push_row("cleared", blank_row());
    push_row("cleared idle", blank_row());
  endtask

  task automatic apply_row(input row_t r);
    fe_v      = r.fe_v;
    fe_pc     = r.fe_pc;
    fe_instr  = r.fe_instr;
    fe_exc    = r.fe_exc;
    iwb_v     = r.iwb_v;
    iwb_rd    = r.iwb_rd;
    iwb_data  = r.iwb_data;
    lwb_v     = r.lwb_v;
    lwb_force = r.lwb_force;
    lwb_rd    = r.lwb_rd;
    lwb_data  = r.lwb_data;
    hazard    = r.hazard;
    resume    = r.resume;
    irq       = r.irq;
    clear     = r.clear;
  endtask

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_kind(input string name, input logic [sched_pkg::KIND_W-1:0] exp,
                            input logic [sched_pkg::KIND_W-1:0] act);
    if (act !== exp)
      abort_run($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp, act));
  endtask

  task automatic check_data(input string name, input logic [sched_pkg::XLEN-1:0] exp,
                            input logic [sched_pkg::XLEN-1:0] act);
    if (act !== exp)
      abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_instr(input string name, input sched_pkg::rv_instr_u exp,
                             input sched_pkg::rv_instr_u act);
    if (act !== exp)
      abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_row(input string name, input row_t r);
    check_bit({name, " valid"}, r.exp_v, dispatch_v);
    check_bit({name, " yumi"}, r.exp_yumi, lwb_yumi);
    check_bit({name, " ready"}, r.exp_ready, fe_ready);
    if (r.exp_v)
    begin
      check_kind({name, " kind"}, r.exp_kind, dispatch_kind);
      check_data({name, " pc"}, sched_pkg::XLEN'(r.exp_pc), sched_pkg::XLEN'(dispatch_pc));
      check_instr({name, " instr"}, r.exp_instr, dispatch_instr);
      check_data({name, " rs1"}, r.exp_rs1, dispatch_rs1);
      check_data({name, " rs2"}, r.exp_rs2, dispatch_rs2);
    end
  endtask

  initial
  begin
    table_ready = 1'b0;
    rst         = 1'b1;
    apply_row(blank_row());
    void'($urandom(55611));
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    foreach (rows[i])
    begin
      apply_row(rows[i]);
      // sample just ahead of the rising edge
      #(CLK_PERIOD * 2 / 5);
      check_row(row_names[i], rows[i]);
      @(negedge clk);
    end
    $display("SIMULATION PASSED");
    $finish;
  end

  initial
  begin
    wait (table_ready);
    #((rows.size() + RESET_CYCLES + MARGIN) * CLK_PERIOD);
    abort_run("timeout: the dispatch table did not finish before the watchdog expired");
  end

endmodule

`default_nettype wire

/* build.f */
sched_pkg.sv
issue_queue.sv
int_regfile.sv
dispatch_arbiter.sv
stride_detector.sv
prefetch_generator.sv
scheduler.sv
tb_scheduler.sv

/* Makefile */
TOP := tb_scheduler

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing -f build.f --top-module $(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
